// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := rx_core_tb
FILELIST  := rx_core.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Test completed successfully

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard hdl/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/adc_capture.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module adc_capture
   import rx_core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  adc_word_t  adc_a_i,
   input  adc_word_t  adc_b_i,
   input  logic       run_i,
   input  logic [7:0] decim_i,
   output iq_t        adc_i_o,
   output iq_t        adc_q_o,
   output logic       strobe_o
);

   localparam int PAD_W = `IQ_W - `ADC_W;

   logic [7:0] decim_cnt;

   //////////////////////////////////////////////////////////////////////
   // Input registers
   //////////////////////////////////////////////////////////////////////

   // Left aligned, zero fill below, A is I and B is Q
   always_ff @(posedge dsp_clk) begin
      adc_i_o <= {adc_a_i, {PAD_W{1'b0}}};
      adc_q_o <= {adc_b_i, {PAD_W{1'b0}}};
   end

   //////////////////////////////////////////////////////////////////////
   // Decimation strobe
   //////////////////////////////////////////////////////////////////////

   // Counter parks at zero while stopped so the
   // first strobe follows run rising by one cycle
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         decim_cnt <= '0;
         strobe_o  <= 1'b0;
      end else if (!run_i) begin
         decim_cnt <= '0;
         strobe_o  <= 1'b0;
      end else if (decim_cnt == '0) begin
         // Reload, giving one strobe per decim+1 cycles
         decim_cnt <= decim_i;
         strobe_o  <= 1'b1;
      end else begin
         decim_cnt <= decim_cnt - 8'd1;
         strobe_o  <= 1'b0;
      end
   end

endmodule

// File: hdl/rx_core.sv
`timescale 1ns/1ps

module rx_core
   import rx_core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  adc_word_t  adc_a_i,
   input  adc_word_t  adc_b_i,
   input  logic       adc_ovf_a_i,
   input  logic       adc_ovf_b_i,
   input  logic       clk_status_i,
   input  logic       credit_i,
   output logic [7:0] leds_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output sample_t    sample_o,
   output logic       sample_valid_o,
   output logic       overrun_o
);

   logic       run;
   logic       clear;
   logic       swap_iq;
   iq_t        dc_off_i;
   iq_t        dc_off_q;
   logic [7:0] decim;
   iq_t        adc_i;
   iq_t        adc_q;
   logic       adc_stb;
   sample_t    fe_sample;
   logic       fe_stb;

   //////////////////////////////////////////////////////////////////////
   // Control
   //////////////////////////////////////////////////////////////////////

   settings_regs settings_regs_inst (
      .dsp_clk      (dsp_clk),
      .por_rst      (por_rst),
      .set_stb_i    (set_stb_i),
      .set_addr_i   (set_addr_i),
      .set_data_i   (set_data_i),
      .clk_status_i (clk_status_i),
      .leds_o       (leds_o),
      .adc_on_a_o   (adc_on_a_o),
      .adc_oe_a_o   (adc_oe_a_o),
      .adc_on_b_o   (adc_on_b_o),
      .adc_oe_b_o   (adc_oe_b_o),
      .swap_iq_o    (swap_iq),
      .dc_off_i_o   (dc_off_i),
      .dc_off_q_o   (dc_off_q),
      .decim_o      (decim),
      .run_o        (run),
      .clear_o      (clear)
   );

   //////////////////////////////////////////////////////////////////////
   // Sample path
   //////////////////////////////////////////////////////////////////////

   // Overflow pins have no consumer in this receive slice
   adc_capture adc_capture_inst (
      .dsp_clk  (dsp_clk),
      .por_rst  (por_rst),
      .adc_a_i  (adc_a_i),
      .adc_b_i  (adc_b_i),
      .run_i    (run),
      .decim_i  (decim),
      .adc_i_o  (adc_i),
      .adc_q_o  (adc_q),
      .strobe_o (adc_stb)
   );

   rx_frontend rx_frontend_inst (
      .dsp_clk    (dsp_clk),
      .por_rst    (por_rst),
      .adc_i_i    (adc_i),
      .adc_q_i    (adc_q),
      .strobe_i   (adc_stb),
      .swap_iq_i  (swap_iq),
      .dc_off_i_i (dc_off_i),
      .dc_off_q_i (dc_off_q),
      .sample_o   (fe_sample),
      .strobe_o   (fe_stb)
   );

   sample_out_fifo sample_out_fifo_inst (
      .dsp_clk        (dsp_clk),
      .por_rst        (por_rst),
      .sample_i       (fe_sample),
      .strobe_i       (fe_stb),
      .clear_i        (clear),
      .credit_i       (credit_i),
      .sample_o       (sample_o),
      .sample_valid_o (sample_valid_o),
      .overrun_o      (overrun_o)
   );

endmodule

// File: hdl/rx_core_defs.svh
`ifndef RX_CORE_DEFS_SVH
`define RX_CORE_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Settings bus map
//////////////////////////////////////////////////////////////////////

// Misc block: ADC control +2, LED value +3, LED source +6
`define SR_MISC        0
// Frontend block: swap +0, DC offset I +1, DC offset Q +2
`define SR_RX_FRONT    24
`define SR_RX_CTRL     32
`define SR_RX_DSP      48

// LED source mask after reset, 1 means hardware driven
`define LED_SRC_RESET  8'h1E

//////////////////////////////////////////////////////////////////////
// Data path widths and buffering
//////////////////////////////////////////////////////////////////////

`define ADC_W          14
`define IQ_W           16
`define RX_FIFO_DEPTH  8
`define RX_CREDITS     `RX_FIFO_DEPTH

`endif

// File: hdl/rx_core_pkg.sv
`include "rx_core_defs.svh"

package rx_core_pkg;

   // Settings bus fields
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;

   // Raw converter word, before padding
   typedef logic [`ADC_W-1:0] adc_word_t;

   // One signed component after padding
   typedef logic signed [`IQ_W-1:0] iq_t;

   // Packed sample word, I on top
   typedef struct packed {
      iq_t i;
      iq_t q;
   } sample_t;

endpackage

// File: hdl/rx_frontend.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module rx_frontend
   import rx_core_pkg::*;
(
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  iq_t     adc_i_i,
   input  iq_t     adc_q_i,
   input  logic    strobe_i,
   input  logic    swap_iq_i,
   input  iq_t     dc_off_i_i,
   input  iq_t     dc_off_q_i,
   output sample_t sample_o,
   output logic    strobe_o
);

   iq_t  st1_i;
   iq_t  st1_q;
   logic st1_stb;

   // Subtract at one extra bit, then clip to the signed range
   function automatic iq_t sub_clip(input iq_t x, input iq_t off);
      logic signed [`IQ_W:0] diff;
      diff = {x[`IQ_W-1], x} - {off[`IQ_W-1], off};
      if (diff[`IQ_W] != diff[`IQ_W-1]) begin
         // Out of range, pick the rail from the true sign
         if (diff[`IQ_W])
            sub_clip = {1'b1, {(`IQ_W-1){1'b0}}};
         else
            sub_clip = {1'b0, {(`IQ_W-1){1'b1}}};
      end else begin
         sub_clip = diff[`IQ_W-1:0];
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stage one, I/Q swap
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      st1_i <= swap_iq_i ? adc_q_i : adc_i_i;
      st1_q <= swap_iq_i ? adc_i_i : adc_q_i;
   end

   //////////////////////////////////////////////////////////////////////
   // Stage two, DC offset and pack
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      sample_o.i <= sub_clip(st1_i, dc_off_i_i);
      sample_o.q <= sub_clip(st1_q, dc_off_q_i);
   end

   // Strobe follows the data through both stages
   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         st1_stb  <= 1'b0;
         strobe_o <= 1'b0;
      end else begin
         st1_stb  <= strobe_i;
         strobe_o <= st1_stb;
      end
   end

endmodule

// File: hdl/sample_out_fifo.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module sample_out_fifo
   import rx_core_pkg::*;
(
   input  logic    dsp_clk,
   input  logic    por_rst,
   input  sample_t sample_i,
   input  logic    strobe_i,
   input  logic    clear_i,
   input  logic    credit_i,
   output sample_t sample_o,
   output logic    sample_valid_o,
   output logic    overrun_o
);

   localparam int PTR_W = $clog2(`RX_FIFO_DEPTH);
   localparam int CNT_W = $clog2(`RX_FIFO_DEPTH + 1);
   localparam int CRD_W = $clog2(`RX_CREDITS + 1);

   sample_t          mem [`RX_FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic [CRD_W-1:0] credit_cnt;
   logic [CRD_W:0]   credit_sum;
   logic             full;
   logic             empty;
   logic             push;
   logic             pop;

   assign full  = (fill == CNT_W'(`RX_FIFO_DEPTH));
   assign empty = (fill == '0);

   // A word leaves whenever one is queued and the consumer has room
   assign pop  = !empty && (credit_cnt != '0);
   assign push = strobe_i && !full && !clear_i;

   assign sample_valid_o = pop;
   assign sample_o       = mem[rd_ptr];

   //////////////////////////////////////////////////////////////////////
   // Storage and pointers
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (push)
         mem[wr_ptr] <= sample_i;
   end

   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + PTR_W'(1);
         if (pop)
            rd_ptr <= rd_ptr + PTR_W'(1);
         case ({push, pop})
            2'b10:   fill <= fill + CNT_W'(1);
            2'b01:   fill <= fill - CNT_W'(1);
            default: fill <= fill;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Credits and overrun
   //////////////////////////////////////////////////////////////////////

   // Never negative since pop needs a credit
   assign credit_sum = {1'b0, credit_cnt} + (CRD_W+1)'(credit_i) - (CRD_W+1)'(pop);

   // Clear leaves the credit count alone, extra returns saturate
   always_ff @(posedge dsp_clk) begin
      if (por_rst)
         credit_cnt <= CRD_W'(`RX_CREDITS);
      else if (credit_sum > (CRD_W+1)'(`RX_CREDITS))
         credit_cnt <= CRD_W'(`RX_CREDITS);
      else
         credit_cnt <= credit_sum[CRD_W-1:0];
   end

   // Sticky until the next run write
   always_ff @(posedge dsp_clk) begin
      if (por_rst || clear_i)
         overrun_o <= 1'b0;
      else if (strobe_i && full)
         overrun_o <= 1'b1;
   end

endmodule

// File: hdl/settings_regs.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module settings_regs
   import rx_core_pkg::*;
(
   input  logic       dsp_clk,
   input  logic       por_rst,
   input  logic       set_stb_i,
   input  set_addr_t  set_addr_i,
   input  set_data_t  set_data_i,
   input  logic       clk_status_i,
   output logic [7:0] leds_o,
   output logic       adc_on_a_o,
   output logic       adc_oe_a_o,
   output logic       adc_on_b_o,
   output logic       adc_oe_b_o,
   output logic       swap_iq_o,
   output iq_t        dc_off_i_o,
   output iq_t        dc_off_q_o,
   output logic [7:0] decim_o,
   output logic       run_o,
   output logic       clear_o
);

   localparam set_addr_t ADDR_ADC_CTRL = set_addr_t'(`SR_MISC + 2);
   localparam set_addr_t ADDR_LED_SW   = set_addr_t'(`SR_MISC + 3);
   localparam set_addr_t ADDR_LED_SRC  = set_addr_t'(`SR_MISC + 6);
   localparam set_addr_t ADDR_SWAP     = set_addr_t'(`SR_RX_FRONT + 0);
   localparam set_addr_t ADDR_DC_I     = set_addr_t'(`SR_RX_FRONT + 1);
   localparam set_addr_t ADDR_DC_Q     = set_addr_t'(`SR_RX_FRONT + 2);
   localparam set_addr_t ADDR_RX_CTRL  = set_addr_t'(`SR_RX_CTRL);
   localparam set_addr_t ADDR_RX_DSP   = set_addr_t'(`SR_RX_DSP);

   logic [3:0] adc_ctrl;
   logic [7:0] led_sw;
   logic [7:0] led_src;
   logic [7:0] led_hw;

   //////////////////////////////////////////////////////////////////////
   // Register bank
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         adc_ctrl   <= '0;
         led_sw     <= '0;
         led_src    <= `LED_SRC_RESET;
         swap_iq_o  <= 1'b0;
         dc_off_i_o <= '0;
         dc_off_q_o <= '0;
         decim_o    <= '0;
         run_o      <= 1'b0;
         clear_o    <= 1'b0;
      end else begin
         clear_o <= 1'b0;
         if (set_stb_i) begin
            case (set_addr_i)
               ADDR_ADC_CTRL: adc_ctrl   <= set_data_i[3:0];
               ADDR_LED_SW:   led_sw     <= set_data_i[7:0];
               ADDR_LED_SRC:  led_src    <= set_data_i[7:0];
               ADDR_SWAP:     swap_iq_o  <= set_data_i[0];
               ADDR_DC_I:     dc_off_i_o <= iq_t'(set_data_i[`IQ_W-1:0]);
               ADDR_DC_Q:     dc_off_q_o <= iq_t'(set_data_i[`IQ_W-1:0]);
               ADDR_RX_DSP:   decim_o    <= set_data_i[7:0];
               ADDR_RX_CTRL: begin
                  // Any run write also flushes the output FIFO
                  run_o   <= set_data_i[0];
                  clear_o <= 1'b1;
               end
               default: ;
            endcase
         end
      end
   end

   // ADC pins, high to low
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_ctrl;

   //////////////////////////////////////////////////////////////////////
   // LED mux
   //////////////////////////////////////////////////////////////////////

   // Hardware status: run on bit 3, clock lock on bit 2
   assign led_hw = {4'b0000, run_o, clk_status_i, 2'b00};

   // Mask bit set selects hardware, clear selects software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: rx_core.f
+incdir+hdl
hdl/rx_core_pkg.sv
hdl/settings_regs.sv
hdl/adc_capture.sv
hdl/rx_frontend.sv
hdl/sample_out_fifo.sv
hdl/rx_core.sv
tests/rx_core_chk.sv
tests/rx_core_tb.sv

// File: tests/rx_core_chk.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module rx_core_chk (
   input logic dsp_clk,
   input logic por_rst,
   input logic valid_i,
   input logic overrun_i,
   input logic clear_i,
   input logic credit_i
);

   localparam int CRD_W = $clog2(`RX_CREDITS + 1);

   // Credits granted by the consumer and not yet used by a word
   logic [CRD_W-1:0] credits_left;

   always_ff @(posedge dsp_clk) begin
      if (por_rst) begin
         credits_left <= CRD_W'(`RX_CREDITS);
      end else if (credit_i && !valid_i) begin
         if (credits_left != CRD_W'(`RX_CREDITS))
            credits_left <= credits_left + CRD_W'(1);
      end else if (!credit_i && valid_i) begin
         if (credits_left != '0)
            credits_left <= credits_left - CRD_W'(1);
      end
   end

   // A word only leaves against a granted credit
   valid_needs_credit: assert property (
      @(posedge dsp_clk) disable iff (por_rst) valid_i |-> (credits_left != '0))
      else $error("sample_valid_o raised with no credit left");

   // Sticky until a run write
   overrun_sticky: assert property (
      @(posedge dsp_clk) disable iff (por_rst) (overrun_i && !clear_i) |=> overrun_i)
      else $error("overrun_o fell without a clear");

   // Quiet output through reset
   valid_low_in_reset: assert property (
      @(posedge dsp_clk) (por_rst && $past(por_rst)) |-> !valid_i)
      else $error("sample_valid_o high during reset");

endmodule

bind sample_out_fifo rx_core_chk rx_core_chk_inst (
   .dsp_clk   (dsp_clk),
   .por_rst   (por_rst),
   .valid_i   (sample_valid_o),
   .overrun_i (overrun_o),
   .clear_i   (clear_i),
   .credit_i  (credit_i)
);

// File: tests/rx_core_patterns.txt
# adc_a adc_b swap dc_i dc_q expected
# ADC words 14-bit hex, offsets 16-bit hex, expected word {I, Q} 32-bit hex
0000 0000 0 0000 0000 00000000
0123 0456 0 0000 0000 048c1158
0123 0456 1 0000 0000 1158048c
1fff 2000 0 fff0 0010 7fff8000
0100 3fff 0 0100 fffc 03000000
2000 1000 1 c000 8000 7fff0000
0abc 3543 0 0af0 ff0c 2000d600

// File: tests/rx_core_tb.sv
`timescale 1ns/1ps
`include "rx_core_defs.svh"

module rx_core_tb
   import rx_core_pkg::*;
();

   localparam set_addr_t A_ADC_CTRL = set_addr_t'(`SR_MISC + 2);
   localparam set_addr_t A_LED_SW   = set_addr_t'(`SR_MISC + 3);
   localparam set_addr_t A_LED_SRC  = set_addr_t'(`SR_MISC + 6);
   localparam set_addr_t A_SWAP     = set_addr_t'(`SR_RX_FRONT);
   localparam set_addr_t A_DC_I     = set_addr_t'(`SR_RX_FRONT + 1);
   localparam set_addr_t A_DC_Q     = set_addr_t'(`SR_RX_FRONT + 2);
   localparam set_addr_t A_RX_CTRL  = set_addr_t'(`SR_RX_CTRL);
   localparam set_addr_t A_RX_DSP   = set_addr_t'(`SR_RX_DSP);

   logic        dsp_clk;
   logic        por_rst;
   logic        set_stb;
   set_addr_t   set_addr;
   set_data_t   set_data;
   adc_word_t   adc_a;
   adc_word_t   adc_b;
   logic        clk_status;
   logic        credit;
   logic [7:0]  leds;
   logic        adc_on_a;
   logic        adc_oe_a;
   logic        adc_on_b;
   logic        adc_oe_b;
   sample_t     sample;
   logic        sample_valid;
   logic        overrun;
   logic [31:0] rx_q [$];
   int          err_cnt;
   int          test_base;
   int          pass_cnt;
   int          fail_cnt;

   rx_core rx_core_inst (
      .dsp_clk        (dsp_clk),
      .por_rst        (por_rst),
      .set_stb_i      (set_stb),
      .set_addr_i     (set_addr),
      .set_data_i     (set_data),
      .adc_a_i        (adc_a),
      .adc_b_i        (adc_b),
      .adc_ovf_a_i    (1'b0),
      .adc_ovf_b_i    (1'b0),
      .clk_status_i   (clk_status),
      .credit_i       (credit),
      .leds_o         (leds),
      .adc_on_a_o     (adc_on_a),
      .adc_oe_a_o     (adc_oe_a),
      .adc_on_b_o     (adc_on_b),
      .adc_oe_b_o     (adc_oe_b),
      .sample_o       (sample),
      .sample_valid_o (sample_valid),
      .overrun_o      (overrun)
   );

   initial begin
      dsp_clk = 1'b0;
      forever #2 dsp_clk = ~dsp_clk;
   end

   // Every word the consumer sees in order
   always @(negedge dsp_clk) begin
      if (!por_rst && sample_valid === 1'b1)
         rx_q.push_back(sample);
   end

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   task automatic tick(input int n);
      repeat (n) begin
         @(posedge dsp_clk);
         #1;
      end
   endtask

   task automatic set_write(input set_addr_t addr, input set_data_t data);
      set_stb  = 1'b1;
      set_addr = addr;
      set_data = data;
      tick(1);
      set_stb  = 1'b0;
   endtask

   task automatic check(input string name, input logic [31:0] expected,
                        input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic wait_words(input int target, input int limit, input string name);
      int cyc;
      cyc = 0;
      while (rx_q.size() < target && cyc < limit) begin
         tick(1);
         cyc++;
      end
      if (rx_q.size() < target) begin
         $display("%s: no output word arrived within %0d cycles", name, limit);
         err_cnt++;
      end
   endtask

   task automatic expect_overrun(input int limit);
      int cyc;
      cyc = 0;
      while (overrun !== 1'b1 && cyc < limit) begin
         tick(1);
         cyc++;
      end
      if (overrun !== 1'b1) begin
         $display("overrun: flag never rose within %0d cycles", limit);
         err_cnt++;
      end
   endtask

   task automatic finish_test(input string name);
      if (err_cnt == test_base) begin
         $display("PASS %s", name);
         pass_cnt++;
      end else begin
         $display("FAIL %s", name);
         fail_cnt++;
      end
      test_base = err_cnt;
   endtask

   // Stop, then give in-flight samples time to drain
   task automatic stop_run();
      set_write(A_RX_CTRL, 32'h0);
      tick(6);
   endtask

   task automatic start_run(input logic [7:0] decim);
      set_write(A_RX_DSP, {24'h0, decim});
      set_write(A_RX_CTRL, 32'h1);
   endtask

   // Mask bit 1 takes hardware status, 0 takes the software value
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw,
                                             input logic run, input logic clk_ok);
      logic [7:0] hw;
      hw    = 8'h00;
      hw[3] = run;
      hw[2] = clk_ok;
      led_expect = (hw & src) | (sw & ~src);
   endfunction

   task automatic run_vector(input int idx, input adc_word_t a, input adc_word_t b,
                             input logic swap, input iq_t dc_i, input iq_t dc_q,
                             input logic [31:0] expected);
      int first;
      stop_run();
      set_write(A_SWAP, {31'h0, swap});
      set_write(A_DC_I, {16'h0, dc_i});
      set_write(A_DC_Q, {16'h0, dc_q});
      adc_a = a;
      adc_b = b;
      tick(3);
      first = rx_q.size();
      start_run(8'd0);
      wait_words(first + 4, 40, $sformatf("frontend vector %0d", idx));
      if (rx_q.size() >= first + 4) begin
         for (int k = 0; k < 4; k++)
            check($sformatf("frontend vector %0d word %0d", idx, k), expected, rx_q[first + k]);
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      int          fd;
      int          code;
      int          vec_cnt;
      int          first;
      int          got;
      int          want;
      int          n_cred;
      string       line;
      adc_word_t   pa;
      adc_word_t   pb;
      logic        psw;
      iq_t         pdi;
      iq_t         pdq;
      logic [31:0] pexp;
      logic [31:0] rnd;
      void'($urandom(32'h8fec3c5a));
      err_cnt    = 0;
      test_base  = 0;
      pass_cnt   = 0;
      fail_cnt   = 0;
      vec_cnt    = 0;
      por_rst    = 1'b1;
      set_stb    = 1'b0;
      set_addr   = '0;
      set_data   = '0;
      adc_a      = '0;
      adc_b      = '0;
      clk_status = 1'b1;
      credit     = 1'b0;
      repeat (10) @(posedge dsp_clk);
      #1 por_rst = 1'b0;
      tick(2);

      check("reset outputs", 32'h0,
            {26'h0, sample_valid, overrun, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b});
      check("reset leds", {24'h0, led_expect(`LED_SRC_RESET, 8'h00, 1'b0, 1'b1)},
            {24'h0, leds});
      finish_test("reset state");

      // Run toggles too so the hardware run bit reaches the LEDs
      for (int n = 0; n < 8; n++) begin
         rnd        = $urandom;
         clk_status = rnd[20];
         set_write(A_LED_SW, {24'h0, rnd[7:0]});
         set_write(A_LED_SRC, {24'h0, rnd[15:8]});
         set_write(A_ADC_CTRL, {28'h0, rnd[19:16]});
         set_write(A_RX_CTRL, {31'h0, rnd[21]});
         tick(1);
         check($sformatf("leds %0d", n),
               {24'h0, led_expect(rnd[15:8], rnd[7:0], rnd[21], rnd[20])},
               {24'h0, leds});
         check($sformatf("adc ctrl %0d", n), {28'h0, rnd[19:16]},
               {28'h0, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b});
      end
      stop_run();
      finish_test("led mux and adc controls");

      // Credits flow freely from here until the credit test
      credit = 1'b1;
      fd = $fopen("tests/rx_core_patterns.txt", "r");
      if (fd == 0) begin
         $display("frontend: could not open tests/rx_core_patterns.txt");
         err_cnt++;
      end else begin
         while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code != 0 && line.len() > 1 && line.getc(0) != "#") begin
               code = $sscanf(line, "%h %h %h %h %h %h", pa, pb, psw, pdi, pdq, pexp);
               if (code == 6) begin
                  run_vector(vec_cnt, pa, pb, psw, pdi, pdq, pexp);
                  vec_cnt++;
               end
            end
         end
         $fclose(fd);
      end
      if (vec_cnt == 0) begin
         $display("frontend: the pattern file held no vectors");
         err_cnt++;
      end
      finish_test("frontend arithmetic");

      for (int d = 0; d < 10; d += 3) begin
         stop_run();
         start_run(8'(d));
         wait_words(rx_q.size() + 1, 40, "decimation");
         first = rx_q.size();
         tick(200);
         got  = rx_q.size() - first;
         want = 200 / (d + 1);
         check($sformatf("decim %0d word count", d), want,
               (got >= want - 1 && got <= want + 1) ? want : got);
      end
      finish_test("decimation");

      stop_run();
      credit = 1'b0;
      first  = rx_q.size();
      start_run(8'd0);
      wait_words(first + `RX_CREDITS, 60, "credit limit");
      tick(20);
      check("credit burst", `RX_CREDITS, rx_q.size() - first);
      n_cred = 1 + int'($urandom % 5);
      first  = rx_q.size();
      for (int n = 0; n < n_cred; n++) begin
         credit = 1'b1;
         tick(1);
         credit = 1'b0;
         tick(int'($urandom % 4));
      end
      tick(20);
      check("credit return", n_cred, rx_q.size() - first);
      finish_test("credit limit");

      // Still running with no credits, so the FIFO overflows
      expect_overrun(40);
      check("overrun set", 32'h1, {31'h0, overrun});
      stop_run();
      check("overrun cleared", 32'h0, {31'h0, overrun});
      set_write(A_SWAP, 32'h0);
      set_write(A_DC_I, 32'h0);
      set_write(A_DC_Q, 32'h0);
      rnd   = $urandom;
      adc_a = rnd[13:0];
      adc_b = rnd[27:14];
      tick(3);
      start_run(8'd0);
      tick(15);
      first  = rx_q.size();
      credit = 1'b1;
      tick(4);
      credit = 1'b0;
      wait_words(first + 4, 20, "overrun");
      if (rx_q.size() >= first + 4) begin
         for (int k = 0; k < 4; k++)
            check($sformatf("overrun word %0d", k), {adc_a, 2'b00, adc_b, 2'b00},
                  rx_q[first + k]);
      end
      finish_test("overrun");

      $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0 && err_cnt == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule
